// ==== source/rv32IsaPkg.sv ====
package rv32IsaPkg;

    localparam int XLEN       = 32; // data path width
    localparam int REG_ADDR_W = 5;  // register index bits, full rv32i range
    localparam int OPCODE_W   = 7;  // instr[6:0]
    localparam int FUNCT3_W   = 3;  // instr[14:12]
    localparam int FUNCT7_W   = 7;  // instr[31:25]

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000; // add, srl and the rest
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // sub and sra only

    typedef enum logic [OPCODE_W-1:0] {
        LOAD   = 7'b0000011, // not handled here
        OP_IMM = 7'b0010011, // alu with immediate
        AUIPC  = 7'b0010111, // needs a pc
        STORE  = 7'b0100011, // no memory port
        OP     = 7'b0110011, // register-register alu
        LUI    = 7'b0110111, // upper immediate
        BRANCH = 7'b1100011, // condition only
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011  // ecall, ebreak, csr
    } opcode_t;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD = 3'd0, F3_SLL = 3'd1, F3_SLT = 3'd2, F3_SLTU = 3'd3,
        F3_XOR = 3'd4, F3_SR  = 3'd5, F3_OR  = 3'd6, F3_AND  = 3'd7
    } aluFunct3_t; // OP and OP_IMM funct3

    typedef enum logic [FUNCT3_W-1:0] {
        F3_BEQ = 3'd0, F3_BNE = 3'd1, F3_BLT  = 3'd4,
        F3_BGE = 3'd5, F3_BLTU = 3'd6, F3_BGEU = 3'd7
    } brFunct3_t; // 2 and 3 are reserved

    typedef enum logic [3:0] {
        ADD = 4'd0, SUB = 4'd1, SLL = 4'd2, SLT = 4'd3, SLTU = 4'd4,
        XOR = 4'd5, SRL = 4'd6, SRA = 4'd7, OR = 4'd8, AND = 4'd9,
        BEQ = 4'd10, BNE = 4'd11, BLT = 4'd12, BGE = 4'd13, BLTU = 4'd14, BGEU = 4'd15
    } aluOp_t; // full 4-bit space used

endpackage

// ==== source/execCtrlPkg.sv ====
package execCtrlPkg;

    import rv32IsaPkg::*;

    // fields pulled out of one instruction word
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;    // first source index
        logic [REG_ADDR_W-1:0] rs2;    // second source index
        logic [REG_ADDR_W-1:0] rd;     // destination index
        opcode_t               opcode; // major opcode
        logic [FUNCT3_W-1:0]   funct3; // meaning depends on opcode
        logic [FUNCT7_W-1:0]   funct7; // alt bit for sub/sra
        logic [XLEN-1:0]       imm;    // sign-extended, per format
        logic                  rangeErr; // index beyond numRegs
    } decoded_t;

    typedef struct packed {
        aluOp_t aluOp;     // operation for the alu
        logic   aluSrcImm; // opB from immediate
        logic   regWrite;  // final write enable, already qualified
        logic   wbSelImm;  // writeback immediate, lui
        logic   isBranch;  // compare only, no writeback
    } ctrlWord_t;

    typedef struct packed {
        logic                  valid;       // accepted the cycle before
        logic [REG_ADDR_W-1:0] rd;          // written register, zero if none
        logic [XLEN-1:0]       data;        // writeback value
        logic                  branchTaken; // branch condition true
        logic                  zero;        // result is zero
        logic                  err;         // instruction rejected
    } execResult_t;

endpackage

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import rv32IsaPkg::*;
    import execCtrlPkg::*;
#(
    parameter int numRegs = 32 // 32 rv32i, 16 rv32e
) (
    input  logic [31:0] instr, // raw instruction word
    output decoded_t    dec    // fields, immediate, range flag
);

    opcode_t         opcode;             // cast of instr[6:0]
    logic [XLEN-1:0] immI, immB, immU;   // candidate immediates
    logic            useRs1, useRs2, useRd; // which indices the format has

    function automatic logic outOfRange(input logic [REG_ADDR_W-1:0] idx);
        return int'(idx) >= numRegs; // only bites for rv32e
    endfunction

    assign opcode = opcode_t'(instr[OPCODE_W-1:0]);

    assign immI = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign immB = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                   instr[11:8], 1'b0}; // bit 0 always zero
    assign immU = {instr[31:12], 12'b0};

    always_comb begin
        useRs1  = 1'b0;
        useRs2  = 1'b0;
        useRd   = 1'b0;
        dec.imm = immI; // i-format unless told otherwise
        case (opcode)
            OP: begin
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                useRd  = 1'b1;
            end
            OP_IMM: begin
                useRs1 = 1'b1;
                useRd  = 1'b1;
            end
            LUI: begin
                useRd   = 1'b1;
                dec.imm = immU;
            end
            BRANCH: begin
                useRs1  = 1'b1;
                useRs2  = 1'b1;
                dec.imm = immB;
            end
            default: ; // control unit rejects these anyway
        endcase

        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        dec.opcode   = opcode;
        dec.funct3   = instr[14:12];
        dec.funct7   = instr[31:25];
        dec.rangeErr = (useRs1 && outOfRange(dec.rs1)) ||
                       (useRs2 && outOfRange(dec.rs2)) ||
                       (useRd && outOfRange(dec.rd)); // unused fields ignored
    end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
    import rv32IsaPkg::*;
    import execCtrlPkg::*;
(
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid, // instruction present this cycle
    input  decoded_t        dec,
    output ctrlWord_t       ctrl,
    input  logic            aluZero,
    input  logic            aluCond,    // branch compare outcome
    input  logic            aluErr,     // alu saw an unknown op
    input  logic [XLEN-1:0] wbData,     // selected writeback value
    output execResult_t     result      // registered record
);

    logic        decErr;     // unsupported or malformed
    logic        anyErr;     // decode or alu error
    logic        writes;     // instruction class has a destination
    logic        f7Base;     // funct7 all zero
    logic        f7Alt;      // funct7 selects sub/sra
    execResult_t resultNext;

    assign f7Base = dec.funct7 == F7_BASE;
    assign f7Alt  = dec.funct7 == F7_ALT;
    assign anyErr = decErr || aluErr;

    always_comb begin
        ctrl.aluOp     = ADD;
        ctrl.aluSrcImm = 1'b0;
        ctrl.wbSelImm  = 1'b0;
        ctrl.isBranch  = 1'b0;
        writes         = 1'b0;
        decErr         = dec.rangeErr;
        case (dec.opcode)
            OP, OP_IMM: begin
                writes         = 1'b1;
                ctrl.aluSrcImm = dec.opcode == OP_IMM;
                case (dec.funct3)
                    F3_ADD:  ctrl.aluOp = (dec.opcode == OP && f7Alt) ? SUB : ADD;
                    F3_SLL:  ctrl.aluOp = SLL;
                    F3_SLT:  ctrl.aluOp = SLT;
                    F3_SLTU: ctrl.aluOp = SLTU;
                    F3_XOR:  ctrl.aluOp = XOR;
                    F3_SR:   ctrl.aluOp = f7Alt ? SRA : SRL;
                    F3_OR:   ctrl.aluOp = OR;
                    default: ctrl.aluOp = AND; // F3_AND
                endcase
                if (dec.opcode == OP) begin
                    decErr |= !(f7Base || (f7Alt && (dec.funct3 == F3_ADD ||
                                                     dec.funct3 == F3_SR)));
                end else if (dec.funct3 == F3_SLL) begin
                    decErr |= !f7Base; // slli shamt top bits
                end else if (dec.funct3 == F3_SR) begin
                    decErr |= !(f7Base || f7Alt); // srli or srai only
                end
            end
            LUI: begin
                writes        = 1'b1;
                ctrl.wbSelImm = 1'b1; // alu result ignored
            end
            BRANCH: begin
                ctrl.isBranch = 1'b1;
                case (dec.funct3)
                    F3_BEQ:  ctrl.aluOp = BEQ;
                    F3_BNE:  ctrl.aluOp = BNE;
                    F3_BLT:  ctrl.aluOp = BLT;
                    F3_BGE:  ctrl.aluOp = BGE;
                    F3_BLTU: ctrl.aluOp = BLTU;
                    F3_BGEU: ctrl.aluOp = BGEU;
                    default: decErr = 1'b1; // reserved funct3
                endcase
            end
            default: decErr = 1'b1; // load, store, jumps, auipc, system
        endcase
        ctrl.regWrite = instrValid && writes && !decErr;
    end

    always_comb begin
        resultNext = '0; // idle cycle gives an all-zero record
        if (instrValid) begin
            resultNext.valid = 1'b1;
            resultNext.err   = anyErr;
            if (!anyErr) begin
                resultNext.rd          = ctrl.regWrite ? dec.rd : '0;
                resultNext.data        = wbData;
                resultNext.branchTaken = ctrl.isBranch && aluCond;
                resultNext.zero        = ctrl.wbSelImm ? (wbData == '0) : aluZero;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
        end else begin
            result <= resultNext; // one cycle latency
        end
    end

    zeroMatchesData: assert property (@(posedge clk) disable iff (!arstN)
        result.valid && !result.err |-> result.zero == (result.data == '0))
        else $error("zero flag disagrees with the reported data");

    errBlocksWrite: assert property (@(posedge clk) disable iff (!arstN)
        instrValid && anyErr |-> !ctrl.regWrite)
        else $error("erroring instruction enabled a register write");

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu
    import rv32IsaPkg::*;
(
    input  aluOp_t          op,   // from control word
    input  logic [XLEN-1:0] opA,  // rs1 data
    input  logic [XLEN-1:0] opB,  // rs2 data or immediate
    output logic [XLEN-1:0] y,
    output logic            zero, // y == 0
    output logic            cond, // branch condition
    output logic            err   // op not recognised
);

    localparam int SHAMT_W = $clog2(XLEN); // 5 bits for rv32

    logic [SHAMT_W-1:0] shamt;    // shift amount, upper opB bits dropped
    logic               eq;       // opA == opB
    logic               ltSigned; // two's complement compare
    logic               ltUnsigned;

    assign shamt      = opB[SHAMT_W-1:0];
    assign eq         = opA == opB;
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        y    = '0; // branches leave y at zero
        cond = 1'b0;
        err  = 1'b0;
        case (op)
            ADD:  y = opA + opB;
            SUB:  y = opA - opB;
            SLL:  y = opA << shamt;
            SLT:  y = {{(XLEN-1){1'b0}}, ltSigned};
            SLTU: y = {{(XLEN-1){1'b0}}, ltUnsigned};
            XOR:  y = opA ^ opB;
            SRL:  y = opA >> shamt;          // zero fill
            SRA:  y = $signed(opA) >>> shamt; // sign fill
            OR:   y = opA | opB;
            AND:  y = opA & opB;
            BEQ:  cond = eq;
            BNE:  cond = !eq;
            BLT:  cond = ltSigned;
            BGE:  cond = !ltSigned;
            BLTU: cond = ltUnsigned;
            BGEU: cond = !ltUnsigned;
            default: begin
                err = 1'b1; // only on x or a corrupted op
            end
        endcase
    end

    assign zero = y == '0;

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
    import rv32IsaPkg::*;
#(
    parameter int numRegs = 32 // 32 rv32i, 16 rv32e
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [REG_ADDR_W-1:0] raddrA, // rs1
    input  logic [REG_ADDR_W-1:0] raddrB, // rs2
    output logic [XLEN-1:0]       rdataA,
    output logic [XLEN-1:0]       rdataB,
    input  logic                  we,     // qualified write enable
    input  logic [REG_ADDR_W-1:0] waddr,  // rd
    input  logic [XLEN-1:0]       wdata
);

    localparam int IDX_W = $clog2(numRegs); // storage index bits

    logic [XLEN-1:0] regs [numRegs]; // x0 slot kept but never written

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin // writes to x0 dropped
            regs[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // combinational reads, new value visible the cycle after the write
    assign rdataA = (raddrA == '0) ? '0 : regs[raddrA[IDX_W-1:0]];
    assign rdataB = (raddrB == '0) ? '0 : regs[raddrB[IDX_W-1:0]];

    wrAddrInRange: assert property (@(posedge clk) disable iff (!arstN)
        we |-> int'(waddr) < numRegs)
        else $error("register write beyond numRegs");

endmodule

// ==== source/execCore.sv ====
`timescale 1ns/1ps

module execCore
    import rv32IsaPkg::*;
    import execCtrlPkg::*;
#(
    parameter int numRegs = 32 // 16 gives an rv32e core
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid, // one instruction per cycle, no stall
    input  logic [31:0] instr,
    output execResult_t result      // one cycle after instrValid
);

    decoded_t        dec;            // decoder to control and regs
    ctrlWord_t       ctrl;           // control to datapath
    logic [XLEN-1:0] rdataA, rdataB; // register read ports
    logic [XLEN-1:0] opB;            // second alu operand
    logic [XLEN-1:0] aluY;
    logic [XLEN-1:0] wbData;         // value for rd and the record
    logic            aluZero, aluCond, aluErr;

    assign opB    = ctrl.aluSrcImm ? dec.imm : rdataB; // i-type uses immediate
    assign wbData = ctrl.wbSelImm ? dec.imm : aluY;    // lui bypasses alu

    instrDecoder #(.numRegs(numRegs)) decoder (
        .instr (instr),
        .dec   (dec)
    );

    controlUnit ctrlUnit (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .dec        (dec),
        .ctrl       (ctrl),
        .aluZero    (aluZero),
        .aluCond    (aluCond),
        .aluErr     (aluErr),
        .wbData     (wbData),
        .result     (result)
    );

    alu aluUnit (
        .op   (ctrl.aluOp),
        .opA  (rdataA),
        .opB  (opB),
        .y    (aluY),
        .zero (aluZero),
        .cond (aluCond),
        .err  (aluErr)
    );

    registerFile #(.numRegs(numRegs)) regs (
        .clk    (clk),
        .arstN  (arstN),
        .raddrA (dec.rs1),
        .raddrB (dec.rs2),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .we     (ctrl.regWrite), // valid, writing class, no error
        .waddr  (dec.rd),
        .wdata  (wbData)
    );

endmodule

// ==== sim/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb
    import execCtrlPkg::*;
();

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 5;
    localparam int    DRIVE_DELAY  = 2;  // ns after the rising edge
    localparam int    NS_PER_LINE  = 40; // one cycle plus a possible idle gap
    localparam int    SEED         = 36;
    localparam string INPUT_FILE   = "sim/execInput.txt";

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    execResult_t result;

    string       testName  [$]; // one entry per file line
    logic [31:0] testInstr [$];
    logic        testValid [$];
    execResult_t testExp   [$]; // expected record one cycle later

    int mismatchCount;
    int otherErrors;
    int checkCount;

    execCore #(.numRegs(32)) uut (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkResult(input string name, input execResult_t expRec,
                               input execResult_t act);
        checkCount++;
        if (act.valid !== expRec.valid || act.rd !== expRec.rd ||
            act.data !== expRec.data) begin
            mismatchCount++;
            $write("MISMATCH %s result: expected valid=%0b rd=%0d data=%08h,",
                   name, expRec.valid, expRec.rd, expRec.data);
            $display(" actual valid=%0b rd=%0d data=%08h", act.valid, act.rd, act.data);
        end
    endtask

    task automatic checkFlags(input string name, input execResult_t expRec,
                              input execResult_t act);
        checkCount++;
        if (act.branchTaken !== expRec.branchTaken || act.zero !== expRec.zero ||
            act.err !== expRec.err) begin
            mismatchCount++;
            $write("MISMATCH %s flags: expected br=%0b zero=%0b err=%0b,",
                   name, expRec.branchTaken, expRec.zero, expRec.err);
            $display(" actual br=%0b zero=%0b err=%0b",
                     act.branchTaken, act.zero, act.err);
        end
    endtask

    task automatic readInput(output bit ok);
        int          fd;
        int          lineNo;
        int          n;
        string       line;
        string       name;
        logic [31:0] word;
        logic [31:0] expData;
        int          valid, expValid, expRd, expBr, expZero, expErr;
        execResult_t expRec;
        ok     = 1'b1;
        lineNo = 0;
        fd     = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open stimulus file %s", INPUT_FILE);
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            lineNo++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue; // comment or blank
            end
            n = $sscanf(line, "%s %h %d %d %d %h %d %d %d", name, word, valid,
                        expValid, expRd, expData, expBr, expZero, expErr);
            if (n != 9) begin
                $display("ERROR: line %0d of %s has %0d fields instead of 9", lineNo,
                         INPUT_FILE, n);
                ok = 1'b0;
                continue;
            end
            expRec             = '0;
            expRec.valid       = expValid[0];
            expRec.rd          = expRd[4:0];
            expRec.data        = expData;
            expRec.branchTaken = expBr[0];
            expRec.zero        = expZero[0];
            expRec.err         = expErr[0];
            testName.push_back(name);
            testInstr.push_back(word);
            testValid.push_back(valid[0]);
            testExp.push_back(expRec);
        end
        $fclose(fd);
        if (testName.size() == 0) begin
            $display("ERROR: no tests found in %s", INPUT_FILE);
            ok = 1'b0;
        end
    endtask

    task automatic runWatchdog(input int limitNs);
        #(limitNs);
        $display("ERROR: watchdog expired after %0d ns before the tests finished",
                 limitNs);
        $display("FAIL: see errors above");
        $finish;
    endtask

    initial begin
        bit          loadOk;
        bit          havePending;
        string       pendingName;
        execResult_t pending;
        int          timeoutNs;
        mismatchCount = 0;
        otherErrors   = 0;
        checkCount    = 0;
        havePending   = 1'b0;
        pendingName   = "";
        pending       = '0;
        void'($urandom(SEED)); // seeded once
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        readInput(loadOk);
        if (!loadOk) begin
            otherErrors++;
        end else begin
            timeoutNs = testName.size() * NS_PER_LINE + RESET_CYCLES * CLK_PERIOD;
            fork
                runWatchdog(timeoutNs);
            join_none
            repeat (RESET_CYCLES) @(posedge clk);
            #(DRIVE_DELAY);
            arstN = 1'b1;
            for (int i = 0; i < testName.size(); i++) begin
                @(posedge clk);
                #(DRIVE_DELAY);
                if (havePending) begin // record of the previous cycle's instruction
                    checkResult(pendingName, pending, result);
                    checkFlags(pendingName, pending, result);
                end
                instrValid  = testValid[i];
                instr       = testInstr[i];
                pendingName = testName[i];
                pending     = testExp[i];
                havePending = 1'b1;
                if (i < testName.size() - 1 && $urandom % 4 == 0) begin
                    @(posedge clk); // random idle gap leaves regs untouched
                    #(DRIVE_DELAY);
                    checkResult(pendingName, pending, result);
                    checkFlags(pendingName, pending, result);
                    instrValid  = 1'b0;
                    instr       = $urandom; // junk word while idle
                    pendingName = "idleGap";
                    pending     = '0;
                end
            end
            @(posedge clk);
            #(DRIVE_DELAY);
            checkResult(pendingName, pending, result); // last line
            checkFlags(pendingName, pending, result);
            instrValid = 1'b0;
        end
        $display("tests %0d, checks %0d, mismatches %0d, other errors %0d",
                 testName.size(), checkCount, mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim/execInput.txt ====
# name instr(hex) instrValid | expected record: valid rd(dec) data(hex) branchTaken zero err
# x1=5, x2=-3, x3=0xF0 set first; branch pairs are (x1,x1) equal, (x2,x1) and (x1,x2)
addiX1        00500093 1  1 1  00000005 0 0 0
addiX2Neg     FFD00113 1  1 2  FFFFFFFD 0 0 0
addiX3        0F000193 1  1 3  000000F0 0 0 0
addX4         00208233 1  1 4  00000002 0 0 0
subX5         402082B3 1  1 5  00000008 0 0 0
andX6         0011F333 1  1 6  00000000 0 1 0
orX7          0011E3B3 1  1 7  000000F5 0 0 0
xorX8         0033C433 1  1 8  00000005 0 0 0
sltX9         001124B3 1  1 9  00000001 0 0 0
sltuX10       00113533 1  1 10 00000000 0 1 0
addChain      005205B3 1  1 11 0000000A 0 0 0
idleNoWrite   06300093 0  0 0  00000000 0 0 0
addiX12       02100613 1  1 12 00000021 0 0 0
sllReg33      00C096B3 1  1 13 0000000A 0 0 0
srlReg33      00C15733 1  1 14 7FFFFFFE 0 0 0
sraRegNeg     40C157B3 1  1 15 FFFFFFFE 0 0 0
slliBy4       00409813 1  1 16 00000050 0 0 0
srliBy28      01C15893 1  1 17 0000000F 0 0 0
sraiBy31      41F15913 1  1 18 FFFFFFFF 0 0 0
luiX19        123459B7 1  1 19 12345000 0 0 0
addiToX0      00708013 1  1 0  0000000C 0 0 0
readX0        00000A33 1  1 20 00000000 0 1 0
beqEqual      00108063 1  1 0  00000000 1 1 0
bneEqual      00109063 1  1 0  00000000 0 1 0
bltEqual      0010C063 1  1 0  00000000 0 1 0
bgeEqual      0010D063 1  1 0  00000000 1 1 0
bltuEqual     0010E063 1  1 0  00000000 0 1 0
bgeuEqual     0010F063 1  1 0  00000000 1 1 0
beqNegPos     00110063 1  1 0  00000000 0 1 0
bneNegPos     00111063 1  1 0  00000000 1 1 0
bltNegPos     00114063 1  1 0  00000000 1 1 0
bgeNegPos     00115063 1  1 0  00000000 0 1 0
bltuNegPos    00116063 1  1 0  00000000 0 1 0
bgeuNegPos    00117063 1  1 0  00000000 1 1 0
beqPosNeg     00208063 1  1 0  00000000 0 1 0
bnePosNeg     00209063 1  1 0  00000000 1 1 0
bltPosNeg     0020C063 1  1 0  00000000 0 1 0
bgePosNeg     0020D063 1  1 0  00000000 1 1 0
bltuPosNeg    0020E063 1  1 0  00000000 1 1 0
bgeuPosNeg    0020F063 1  1 0  00000000 0 1 0
loadRejected  0000AA83 1  1 0  00000000 0 0 1
jalRejected   00000AEF 1  1 0  00000000 0 0 1
mulRejected   02108AB3 1  1 0  00000000 0 0 1
ecallRejected 00000073 1  1 0  00000000 0 0 1
brF3Reserved  0010A063 1  1 0  00000000 0 0 1
readX21       000A8B33 1  1 22 00000000 0 1 0

// ==== sources.f ====
source/rv32IsaPkg.sv
source/execCtrlPkg.sv
source/instrDecoder.sv
source/controlUnit.sv
source/alu.sv
source/registerFile.sv
source/execCore.sv
sim/execCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the execute core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module execCoreTb -f sources.f -Mdir obj_dir
	./obj_dir/VexecCoreTb | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
